//--- hdl/ps_bus_pkg.sv
// Shared definitions for the PS bus bridge
// Bus widths, ack timeout, address map and register offsets
// AXI response codes and the bus opcode enum

`default_nettype none

package ps_bus_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Cycles the master waits for ack before giving up
  localparam int ACK_TIMEOUT = 32;
  localparam int ACK_CNT_W   = $clog2(ACK_TIMEOUT);

  //////////////////////////////
  // Address map
  //////////////////////////////
  localparam int REGION_LSB = 20;
  localparam int REGION_W   = 2;

  // Codes 2 and 3 are unmapped
  localparam logic [REGION_W-1:0] REGION_REGS = 2'd0;
  localparam logic [REGION_W-1:0] REGION_EXT  = 2'd1;

  // Byte offsets inside the register region
  localparam logic [REGION_LSB-1:0] REG_ID      = 'h00;
  localparam logic [REGION_LSB-1:0] REG_SCRATCH = 'h04;
  localparam logic [REGION_LSB-1:0] REG_CONTROL = 'h08;
  localparam logic [REGION_LSB-1:0] REG_WCOUNT  = 'h0C;

  localparam logic [DATA_W-1:0] PS_ID_VALUE = 32'h5052_0001;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } bus_op_e;

endpackage

`default_nettype wire

//--- hdl/sys_bus_if.sv
// System bus interface
// Master drives address, data and strobes; slave returns ack

`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if;
  import ps_bus_pkg::*;

  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] sel;
  logic              wen;
  logic              ren;
  // Valid in the ack cycle only
  logic [DATA_W-1:0] rdata;
  logic              err;
  logic              ack;

  modport m (
    output addr, wdata, sel, wen, ren,
    input  rdata, err, ack
  );

  modport s (
    input  addr, wdata, sel, wen, ren,
    output rdata, err, ack
  );

endinterface

`default_nettype wire

//--- hdl/ps_req_if.sv
// Request interface from AXI capture to the bus master

`timescale 1ns/1ps
`default_nettype none

interface ps_req_if;
  import ps_bus_pkg::*;

  logic              vld;
  bus_op_e           op;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              rdy;

  modport src (output vld, op, addr, wdata, wstrb, input rdy);
  modport dst (input vld, op, addr, wdata, wstrb, output rdy);

endinterface

`default_nettype wire

//--- hdl/axi_lite_capture.sv
// AXI4-Lite request capture
// Pairs AW and W into a write, or takes an AR read, and holds
// one request until the bus master takes it

`timescale 1ns/1ps
`default_nettype none

module axi_lite_capture (
  input  logic                          clk,
  input  logic                          reset_i,
  // Write address channel
  input  logic                          awvalid_i,
  input  logic [ps_bus_pkg::ADDR_W-1:0] awaddr_i,
  output logic                          awready_o,
  // Write data channel
  input  logic                          wvalid_i,
  input  logic [ps_bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [ps_bus_pkg::STRB_W-1:0] wstrb_i,
  output logic                          wready_o,
  // Read address channel
  input  logic                          arvalid_i,
  input  logic [ps_bus_pkg::ADDR_W-1:0] araddr_i,
  output logic                          arready_o,
  // Towards the bus master
  ps_req_if.src                         req
);
  import ps_bus_pkg::*;

  logic wr_pend;
  logic take_wr;
  logic take_rd;

  //////////////////////////////
  // Acceptance
  //////////////////////////////

  // A write needs address and data at the same time
  assign wr_pend = awvalid_i && wvalid_i;

  // Only an empty holding register accepts, writes first
  assign take_wr = !req.vld && wr_pend;
  assign take_rd = !req.vld && arvalid_i && !wr_pend;

  // AW and W are taken together
  assign awready_o = take_wr;
  assign wready_o  = take_wr;
  assign arready_o = take_rd;

  //////////////////////////////
  // Holding register
  //////////////////////////////

  // Full flag doubles as the request valid
  always_ff @(posedge clk) begin
    if (reset_i) begin
      req.vld <= 1'b0;
    end else if (take_wr || take_rd) begin
      req.vld <= 1'b1;
    end else if (req.rdy) begin
      req.vld <= 1'b0;
    end
  end

  // Request payload
  always_ff @(posedge clk) begin
    if (take_wr) begin
      req.op    <= OP_WRITE;
      req.addr  <= awaddr_i;
      req.wdata <= wdata_i;
      req.wstrb <= wstrb_i;
    end else if (take_rd) begin
      req.op    <= OP_READ;
      req.addr  <= araddr_i;
      // No byte lanes on a read
      req.wdata <= '0;
      req.wstrb <= '0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/sys_bus_master.sv
// System bus master
// Turns one request into a wen or ren pulse, waits for ack or
// timeout and returns the result on the AXI B or R channel

`timescale 1ns/1ps
`default_nettype none

module sys_bus_master (
  input  logic                          clk,
  input  logic                          reset_i,
  // Write response channel
  output logic                          bvalid_o,
  output logic [1:0]                    bresp_o,
  input  logic                          bready_i,
  // Read data channel
  output logic                          rvalid_o,
  output logic [ps_bus_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  input  logic                          rready_i,
  ps_req_if.dst                         req,
  sys_bus_if.m                          bus
);
  import ps_bus_pkg::*;

  typedef enum logic [1:0] {IDLE, STROBE, WAIT_ACK, RESPOND} state_e;

  state_e               state;
  bus_op_e              op;
  logic [ADDR_W-1:0]    addr;
  logic [DATA_W-1:0]    wdata;
  logic [STRB_W-1:0]    wstrb;
  logic [DATA_W-1:0]    rdata;
  logic                 resp_err;
  logic [1:0]           resp_code;
  logic [ACK_CNT_W-1:0] tmo_cnt;
  logic                 tmo_hit;
  logic                 busy;
  logic                 resp_done;

  assign req.rdy = (state == IDLE);
  // Ack may come in the strobe cycle already
  assign busy    = (state == STROBE) || (state == WAIT_ACK);
  assign tmo_hit = (state == WAIT_ACK) && !bus.ack &&
                   (tmo_cnt == ACK_CNT_W'(ACK_TIMEOUT - 1));
  assign resp_done = (op == OP_WRITE) ? bready_i : rready_i;

  //////////////////////////////
  // FSM and timeout counter
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= IDLE;
      tmo_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req.vld) begin
            state <= STROBE;
          end
        end
        STROBE: begin
          tmo_cnt <= '0;
          state   <= bus.ack ? RESPOND : WAIT_ACK;
        end
        WAIT_ACK: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (bus.ack || tmo_hit) begin
            state <= RESPOND;
          end
        end
        RESPOND: begin
          if (resp_done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request and result latches
  always_ff @(posedge clk) begin
    if (req.vld && req.rdy) begin
      op    <= req.op;
      addr  <= req.addr;
      wdata <= req.wdata;
      wstrb <= req.wstrb;
    end
    if (busy && bus.ack) begin
      rdata    <= bus.rdata;
      resp_err <= bus.err;
    end else if (tmo_hit) begin
      rdata    <= '0;
      resp_err <= 1'b1;
    end
  end

  // Bus side
  assign bus.addr  = addr;
  assign bus.wdata = wdata;
  assign bus.sel   = wstrb;
  assign bus.wen   = (state == STROBE) && (op == OP_WRITE);
  assign bus.ren   = (state == STROBE) && (op == OP_READ);

  // AXI response side
  assign resp_code = resp_err ? RESP_SLVERR : RESP_OKAY;
  assign bvalid_o  = (state == RESPOND) && (op == OP_WRITE);
  assign bresp_o   = resp_code;
  assign rvalid_o  = (state == RESPOND) && (op == OP_READ);
  assign rdata_o   = rdata;
  assign rresp_o   = resp_code;

endmodule

`default_nettype wire

//--- hdl/sys_bus_decoder.sv
// System bus address decoder
// Routes strobes by region to the register block or the external
// port, and answers unmapped regions with an error

`timescale 1ns/1ps
`default_nettype none

module sys_bus_decoder (
  input  logic                          clk,
  input  logic                          reset_i,
  sys_bus_if.s                          up,
  sys_bus_if.m                          regs,
  // External system bus
  output logic [ps_bus_pkg::ADDR_W-1:0] ext_addr_o,
  output logic [ps_bus_pkg::DATA_W-1:0] ext_wdata_o,
  output logic [ps_bus_pkg::STRB_W-1:0] ext_sel_o,
  output logic                          ext_wen_o,
  output logic                          ext_ren_o,
  input  logic [ps_bus_pkg::DATA_W-1:0] ext_rdata_i,
  input  logic                          ext_err_i,
  input  logic                          ext_ack_i
);
  import ps_bus_pkg::*;

  logic [REGION_W-1:0] region;
  logic                sel_regs;
  logic                sel_ext;
  logic                unm_ack;

  // Address stays stable for the whole cycle
  assign region   = up.addr[REGION_LSB +: REGION_W];
  assign sel_regs = (region == REGION_REGS);
  assign sel_ext  = (region == REGION_EXT);

  //////////////////////////////
  // Forward path
  //////////////////////////////
  assign regs.addr  = up.addr;
  assign regs.wdata = up.wdata;
  assign regs.sel   = up.sel;
  assign regs.wen   = up.wen && sel_regs;
  assign regs.ren   = up.ren && sel_regs;

  assign ext_addr_o  = up.addr;
  assign ext_wdata_o = up.wdata;
  assign ext_sel_o   = up.sel;
  assign ext_wen_o   = up.wen && sel_ext;
  assign ext_ren_o   = up.ren && sel_ext;

  // Unmapped strobe gets an ack one cycle later
  always_ff @(posedge clk) begin
    if (reset_i) begin
      unm_ack <= 1'b0;
    end else begin
      unm_ack <= (up.wen || up.ren) && !sel_regs && !sel_ext;
    end
  end

  //////////////////////////////
  // Return path
  //////////////////////////////
  always_comb begin
    if (sel_regs) begin
      up.ack   = regs.ack;
      up.rdata = regs.rdata;
      up.err   = regs.err;
    end else if (sel_ext) begin
      up.ack   = ext_ack_i;
      up.rdata = ext_rdata_i;
      up.err   = ext_err_i;
    end else begin
      up.ack   = unm_ack;
      up.rdata = '0;
      up.err   = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/ps_regs.sv
// Built-in register block
// ID, scratch, control and write counter registers on the system bus

`timescale 1ns/1ps
`default_nettype none

module ps_regs (
  input  logic       clk,
  input  logic       reset_i,
  sys_bus_if.s       bus,
  output logic [7:0] leds_o
);
  import ps_bus_pkg::*;

  logic [REGION_LSB-1:0] offs;
  logic [DATA_W-1:0]     scratch;
  logic [DATA_W-1:0]     control;
  logic [DATA_W-1:0]     wcount;
  logic                  wr_ok;

  // Byte lane merge for the writable registers
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_val,
    input logic [DATA_W-1:0] new_val,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign offs  = bus.addr[REGION_LSB-1:0];
  // ID and WCOUNT are read only
  assign wr_ok = bus.wen && ((offs == REG_SCRATCH) || (offs == REG_CONTROL));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      scratch <= '0;
      control <= '0;
      wcount  <= '0;
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.wen || bus.ren;
      if (bus.wen && (offs == REG_SCRATCH)) begin
        scratch <= merge_bytes(scratch, bus.wdata, bus.sel);
      end
      if (bus.wen && (offs == REG_CONTROL)) begin
        control <= merge_bytes(control, bus.wdata, bus.sel);
      end
      if (wr_ok) begin
        wcount <= wcount + 1'b1;
      end
    end
  end

  // Read data and error, seen in the ack cycle
  always_ff @(posedge clk) begin
    if (bus.ren) begin
      case (offs)
        REG_ID:      bus.rdata <= PS_ID_VALUE;
        REG_SCRATCH: bus.rdata <= scratch;
        REG_CONTROL: bus.rdata <= control;
        REG_WCOUNT:  bus.rdata <= wcount;
        default:     bus.rdata <= '0;
      endcase
    end
    bus.err <= bus.wen && !wr_ok;
  end

  assign leds_o = control[7:0];

endmodule

`default_nettype wire

//--- hdl/red_pitaya_ps_bus.sv
// PS bus bridge top level
// AXI4-Lite slave in, register block and external system bus out

`timescale 1ns/1ps
`default_nettype none

module red_pitaya_ps_bus (
  input  logic                          clk,
  input  logic                          reset_i,
  // AXI4-Lite slave, GP0 side
  input  logic                          awvalid_i,
  input  logic [ps_bus_pkg::ADDR_W-1:0] awaddr_i,
  output logic                          awready_o,
  input  logic                          wvalid_i,
  input  logic [ps_bus_pkg::DATA_W-1:0] wdata_i,
  input  logic [ps_bus_pkg::STRB_W-1:0] wstrb_i,
  output logic                          wready_o,
  output logic                          bvalid_o,
  output logic [1:0]                    bresp_o,
  input  logic                          bready_i,
  input  logic                          arvalid_i,
  input  logic [ps_bus_pkg::ADDR_W-1:0] araddr_i,
  output logic                          arready_o,
  output logic                          rvalid_o,
  output logic [ps_bus_pkg::DATA_W-1:0] rdata_o,
  output logic [1:0]                    rresp_o,
  input  logic                          rready_i,
  // External system bus
  output logic [ps_bus_pkg::ADDR_W-1:0] ext_addr_o,
  output logic [ps_bus_pkg::DATA_W-1:0] ext_wdata_o,
  output logic [ps_bus_pkg::STRB_W-1:0] ext_sel_o,
  output logic                          ext_wen_o,
  output logic                          ext_ren_o,
  input  logic [ps_bus_pkg::DATA_W-1:0] ext_rdata_i,
  input  logic                          ext_err_i,
  input  logic                          ext_ack_i,
  output logic [7:0]                    leds_o
);

  ps_req_if  req_if ();
  sys_bus_if up_bus ();
  sys_bus_if reg_bus ();

  //////////////////////////////
  // AXI front end
  //////////////////////////////
  axi_lite_capture u_capture (
    .clk       (clk),
    .reset_i   (reset_i),
    .awvalid_i (awvalid_i),
    .awaddr_i  (awaddr_i),
    .awready_o (awready_o),
    .wvalid_i  (wvalid_i),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wready_o  (wready_o),
    .arvalid_i (arvalid_i),
    .araddr_i  (araddr_i),
    .arready_o (arready_o),
    .req       (req_if)
  );

  sys_bus_master u_master (
    .clk      (clk),
    .reset_i  (reset_i),
    .bvalid_o (bvalid_o),
    .bresp_o  (bresp_o),
    .bready_i (bready_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o),
    .rresp_o  (rresp_o),
    .rready_i (rready_i),
    .req      (req_if),
    .bus      (up_bus)
  );

  //////////////////////////////
  // Address decode and targets
  //////////////////////////////
  sys_bus_decoder u_decoder (
    .clk         (clk),
    .reset_i     (reset_i),
    .up          (up_bus),
    .regs        (reg_bus),
    .ext_addr_o  (ext_addr_o),
    .ext_wdata_o (ext_wdata_o),
    .ext_sel_o   (ext_sel_o),
    .ext_wen_o   (ext_wen_o),
    .ext_ren_o   (ext_ren_o),
    .ext_rdata_i (ext_rdata_i),
    .ext_err_i   (ext_err_i),
    .ext_ack_i   (ext_ack_i)
  );

  ps_regs u_regs (
    .clk     (clk),
    .reset_i (reset_i),
    .bus     (reg_bus),
    .leds_o  (leds_o)
  );

endmodule

`default_nettype wire

//--- verif/tb_ps_bus.sv
// Testbench for the PS bus bridge
// Clock and reset, external slave model, AXI tasks,
// in-order response checker, assertions and watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_ps_bus;
  import ps_bus_pkg::*;

  localparam int CLK_NS      = 40;
  localparam int N_TXN       = 100;
  localparam int WATCHDOG_NS = (N_TXN * (ACK_TIMEOUT + 30) + 200) * CLK_NS;
  localparam logic [ADDR_W-1:0] EXT_BASE = ADDR_W'(REGION_EXT) << REGION_LSB;

  // One expected response, kept in issue order
  typedef struct packed {
    logic              is_rd;
    logic              chk;
    logic [1:0]        resp;
    logic [DATA_W-1:0] data;
  } exp_t;

  logic              clk;
  logic              reset_i;
  logic              awvalid_i, wvalid_i, arvalid_i, bready_i, rready_i;
  logic [ADDR_W-1:0] awaddr_i, araddr_i;
  logic [DATA_W-1:0] wdata_i;
  logic [STRB_W-1:0] wstrb_i;
  logic              awready_o, wready_o, arready_o, bvalid_o, rvalid_o;
  logic [1:0]        bresp_o, rresp_o;
  logic [DATA_W-1:0] rdata_o;
  logic [ADDR_W-1:0] ext_addr_o;
  logic [DATA_W-1:0] ext_wdata_o, ext_rdata_i;
  logic [STRB_W-1:0] ext_sel_o;
  logic              ext_wen_o, ext_ren_o, ext_err_i, ext_ack_i;
  logic [7:0]        leds_o;

  exp_t              exp_q[$];
  int                errors = 0;
  int                n_done = 0;
  logic              started = 1'b0;
  logic              ext_mute = 1'b0;
  logic              ext_fail = 1'b0;
  logic [DATA_W-1:0] ext_mem[16];
  logic [DATA_W-1:0] ext_ref[16];
  logic [DATA_W-1:0] scratch_ref = '0;
  logic [DATA_W-1:0] control_ref = '0;
  logic [DATA_W-1:0] wcount_ref  = '0;

  red_pitaya_ps_bus uut (
    .clk (clk), .reset_i (reset_i),
    .awvalid_i (awvalid_i), .awaddr_i (awaddr_i), .awready_o (awready_o),
    .wvalid_i (wvalid_i), .wdata_i (wdata_i), .wstrb_i (wstrb_i), .wready_o (wready_o),
    .bvalid_o (bvalid_o), .bresp_o (bresp_o), .bready_i (bready_i),
    .arvalid_i (arvalid_i), .araddr_i (araddr_i), .arready_o (arready_o),
    .rvalid_o (rvalid_o), .rdata_o (rdata_o), .rresp_o (rresp_o), .rready_i (rready_i),
    .ext_addr_o (ext_addr_o), .ext_wdata_o (ext_wdata_o), .ext_sel_o (ext_sel_o),
    .ext_wen_o (ext_wen_o), .ext_ren_o (ext_ren_o), .ext_rdata_i (ext_rdata_i),
    .ext_err_i (ext_err_i), .ext_ack_i (ext_ack_i), .leds_o (leds_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  function automatic logic [DATA_W-1:0] fill_word(input int idx);
    return 32'hE500_0000 ^ (32'(idx) * 32'h0011_0203);
  endfunction

  // New bytes where strobed, old bytes elsewhere
  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old_val,
      input logic [DATA_W-1:0] new_val, input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < STRB_W; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  //////////////////////////////
  // AXI master tasks
  //////////////////////////////
  task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic [STRB_W-1:0] strb, input logic [1:0] resp);
    exp_t e;
    e = '{is_rd: 1'b0, chk: 1'b0, resp: resp, data: '0};
    exp_q.push_back(e);
    awvalid_i = 1'b1;
    awaddr_i  = addr;
    wvalid_i  = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    do @(posedge clk); while (!awready_o);
    assert (wready_o) else begin
      errors++;
      $display("%0t: awready was raised without wready", $time);
    end
    @(negedge clk);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
      input logic chk, input logic [1:0] resp);
    exp_t e;
    e = '{is_rd: 1'b1, chk: chk, resp: resp, data: data};
    exp_q.push_back(e);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    do @(posedge clk); while (!arready_o);
    @(negedge clk);
    arvalid_i = 1'b0;
  endtask

  task automatic reg_write(input logic [REGION_LSB-1:0] offs, input logic [DATA_W-1:0] data,
      input logic [STRB_W-1:0] strb);
    logic [1:0] resp;
    resp = RESP_OKAY;
    if (offs == REG_SCRATCH) begin
      scratch_ref = apply_strobes(scratch_ref, data, strb);
      wcount_ref++;
    end else if (offs == REG_CONTROL) begin
      control_ref = apply_strobes(control_ref, data, strb);
      wcount_ref++;
    end else begin
      resp = RESP_SLVERR;
    end
    axi_write(ADDR_W'(offs), data, strb, resp);
  endtask

  task automatic reg_read(input logic [REGION_LSB-1:0] offs);
    logic [DATA_W-1:0] val;
    case (offs)
      REG_ID:      val = PS_ID_VALUE;
      REG_SCRATCH: val = scratch_ref;
      REG_CONTROL: val = control_ref;
      REG_WCOUNT:  val = wcount_ref;
      default:     val = '0;
    endcase
    axi_read(ADDR_W'(offs), val, 1'b1, RESP_OKAY);
  endtask

  task automatic ext_write(input logic [3:0] idx, input logic [DATA_W-1:0] data,
      input logic [STRB_W-1:0] strb);
    logic ok;
    ok = !ext_mute && !ext_fail;
    if (ok) begin
      ext_ref[idx] = apply_strobes(ext_ref[idx], data, strb);
    end
    axi_write(EXT_BASE | ADDR_W'({idx, 2'b00}), data, strb, ok ? RESP_OKAY : RESP_SLVERR);
  endtask

  task automatic ext_read(input logic [3:0] idx);
    logic ok;
    ok = !ext_mute && !ext_fail;
    axi_read(EXT_BASE | ADDR_W'({idx, 2'b00}), ext_ref[idx], ok,
             ok ? RESP_OKAY : RESP_SLVERR);
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  //////////////////////////////
  // External slave model
  //////////////////////////////
  initial begin : ext_slave
    int                delay;
    logic [3:0]        idx;
    logic              is_wr;
    logic [DATA_W-1:0] wd;
    logic [STRB_W-1:0] sel;
    ext_ack_i   = 1'b0;
    ext_err_i   = 1'b0;
    ext_rdata_i = '0;
    for (int i = 0; i < 16; i++) begin
      ext_mem[i] = fill_word(i);
    end
    forever begin
      @(negedge clk);
      ext_ack_i   = 1'b0;
      ext_err_i   = 1'b0;
      ext_rdata_i = '0;
      if (!reset_i && (ext_wen_o || ext_ren_o)) begin
        is_wr = ext_wen_o;
        idx   = ext_addr_o[5:2];
        wd    = ext_wdata_o;
        sel   = ext_sel_o;
        // A muted slave leaves the master to time out
        if (!ext_mute) begin
          delay = $urandom % 11;
          repeat (delay) @(negedge clk);
          if (is_wr && !ext_fail) begin
            ext_mem[idx] = apply_strobes(ext_mem[idx], wd, sel);
          end
          ext_ack_i   = 1'b1;
          ext_err_i   = ext_fail;
          ext_rdata_i = ext_mem[idx];
        end
      end
    end
  end

  // Random bready and rready stalls, responses checked in issue order
  initial begin : collect
    exp_t e;
    bready_i = 1'b0;
    rready_i = 1'b0;
    forever begin
      @(negedge clk);
      bready_i = started && (($urandom % 3) != 0);
      rready_i = started && (($urandom % 3) != 0);
      @(posedge clk);
      if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("%0t: a response arrived with no request outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          n_done++;
          assert (e.is_rd == rvalid_o) else begin
            errors++;
            $display("%0t: response came on the wrong channel", $time);
          end
          assert (!bvalid_o || bresp_o == e.resp) else begin
            errors++;
            $display("FAILED %0t: bresp %0d, expected %0d", $time, bresp_o, e.resp);
          end
          assert (!rvalid_o || rresp_o == e.resp) else begin
            errors++;
            $display("FAILED %0t: rresp %0d, expected %0d", $time, rresp_o, e.resp);
          end
          assert (!rvalid_o || !e.chk || rdata_o == e.data) else begin
            errors++;
            $display("FAILED %0t: rdata %h, expected %h", $time, rdata_o, e.data);
          end
        end
      end
    end
  end

  //////////////////////////////
  // Protocol assertions
  //////////////////////////////
  assert property (@(posedge clk) disable iff (reset_i)
    (ext_wen_o || ext_ren_o) |=> !(ext_wen_o || ext_ren_o))
    else begin
      errors++;
      $display("%0t: external strobe lasted longer than one cycle", $time);
    end

  assert property (@(posedge clk) disable iff (reset_i)
    (bvalid_o && !bready_i) |=> (bvalid_o && $stable(bresp_o)))
    else begin
      errors++;
      $display("%0t: bvalid dropped or bresp changed before bready", $time);
    end

  assert property (@(posedge clk) disable iff (reset_i)
    (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o) && $stable(rresp_o)))
    else begin
      errors++;
      $display("%0t: rvalid dropped or read data changed before rready", $time);
    end

  // Quiet outputs between reset and the first request
  assert property (@(posedge clk) disable iff (reset_i)
    !started |-> !(awready_o || wready_o || arready_o || bvalid_o || rvalid_o ||
                   ext_wen_o || ext_ren_o || (leds_o != 8'h00)))
    else begin
      errors++;
      $display("%0t: an output was active after reset before any request", $time);
    end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired with %0d responses outstanding", exp_q.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin : main
    void'($urandom(32'h084614c4));
    reset_i   = 1'b1;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    for (int i = 0; i < 16; i++) begin
      ext_ref[i] = fill_word(i);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    repeat (3) @(negedge clk);
    started = 1'b1;

    // Register block
    reg_read(REG_ID);
    for (int i = 0; i < 8; i++) begin
      reg_write(REG_SCRATCH, $urandom, (i == 0) ? 4'hF : STRB_W'($urandom));
      reg_read(REG_SCRATCH);
    end
    for (int i = 0; i < 3; i++) begin
      reg_write(REG_CONTROL, $urandom, (i == 0) ? 4'hF : (STRB_W'($urandom) | 4'h1));
      wait_idle();
      assert (leds_o == control_ref[7:0]) else begin
        errors++;
        $display("FAILED %0t: leds_o %h, expected %h", $time, leds_o, control_ref[7:0]);
      end
    end
    reg_read(REG_CONTROL);

    // Read-only and undefined offsets are not counted
    reg_write(REG_ID, $urandom, 4'hF);
    reg_write(REG_WCOUNT, $urandom, 4'hF);
    reg_write(20'h10, $urandom, 4'hF);
    reg_write(20'h40, $urandom, 4'h3);
    reg_read(20'h10);
    reg_read(REG_WCOUNT);

    // External region
    for (int i = 0; i < 16; i++) begin
      ext_write(4'($urandom), $urandom, STRB_W'($urandom));
    end
    for (int i = 0; i < 16; i++) begin
      ext_read(4'(i));
    end
    wait_idle();
    ext_fail = 1'b1;
    ext_write(4'd3, $urandom, 4'hF);
    ext_read(4'd3);
    wait_idle();
    ext_fail = 1'b0;
    ext_read(4'd3);

    // Unmapped regions 2 and 3
    axi_write(32'h0020_0000, $urandom, 4'hF, RESP_SLVERR);
    axi_read(32'h0020_0004, '0, 1'b1, RESP_SLVERR);
    axi_write(32'h0030_0010, $urandom, 4'hF, RESP_SLVERR);
    axi_read(32'h0030_0008, '0, 1'b1, RESP_SLVERR);

    // Ack timeout, then recovery
    wait_idle();
    ext_mute = 1'b1;
    ext_write(4'd5, 32'hDEAD_BEEF, 4'hF);
    wait_idle();
    ext_mute = 1'b0;
    ext_read(4'd5);
    reg_read(REG_WCOUNT);

    // Mixed traffic back to back
    for (int i = 0; i < 24; i++) begin
      case ($urandom % 4)
        0: reg_write(($urandom % 2) ? REG_SCRATCH : REG_CONTROL, $urandom, STRB_W'($urandom));
        1: reg_read(REGION_LSB'(4 * ($urandom % 4)));
        2: ext_write(4'($urandom), $urandom, STRB_W'($urandom));
        default: ext_read(4'($urandom));
      endcase
    end

    wait_idle();
    repeat (4) @(negedge clk);
    $display("Responses checked: %0d, errors: %0d", n_done, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ps_bus.f
hdl/ps_bus_pkg.sv
hdl/sys_bus_if.sv
hdl/ps_req_if.sv
hdl/axi_lite_capture.sv
hdl/sys_bus_master.sv
hdl/sys_bus_decoder.sv
hdl/ps_regs.sv
hdl/red_pitaya_ps_bus.sv
verif/tb_ps_bus.sv
